//--- sources.f
hdl/dcache_pkg.sv
hdl/dcache_way.sv
hdl/dcache_merge.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
test/tb_mem_model.sv
test/tb_dcache.sv

//--- test/tb_dcache.sv
// --------------------
// dcache testbench
// directed and random cpu traffic, checked against a
// flat reference memory and an LRU model of each set
// --------------------

`timescale 1ns/10ps

module tb_dcache;

    localparam int TIMEOUT_CYCLES = 20000;   // ~300 accesses of at most 40 cycles

    typedef struct packed {
        logic              valid;
        logic              dirty;
        dcache_pkg::addr_t line;
    } model_line_t;

    logic                 clk;
    logic                 rst_n;
    logic                 cpu_valid_i;
    dcache_pkg::cpu_req_t cpu_req_i;
    logic                 cpu_ack_o;
    dcache_pkg::word_t    cpu_rdata_o;
    logic                 mem_req_o;
    logic                 mem_we_o;
    dcache_pkg::addr_t    mem_addr_o;
    dcache_pkg::line_t    mem_wdata_o;
    logic                 mem_ack_i;
    dcache_pkg::line_t    mem_rdata_i;
    logic [15:0]          wb_count;

    dcache_pkg::word_t    ref_mem [1024];     // same 4 KB window as the memory model
    model_line_t          mru [dcache_pkg::SETS];
    model_line_t          lru [dcache_pkg::SETS];
    logic                 xfer_we_q [$];
    dcache_pkg::addr_t    xfer_addr_q [$];
    dcache_pkg::line_t    wb_data_q [$];
    int                   req_cycles;
    int                   cycle_count;
    logic [31:0]          rng;

    dcache_top dut_i (.*);

    tb_mem_model #(.SEED(32'd56)) mem_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (mem_req_o),
        .we_i       (mem_we_o),
        .addr_i     (mem_addr_o),
        .wdata_i    (mem_wdata_o),
        .ack_o      (mem_ack_i),
        .rdata_o    (mem_rdata_i),
        .wb_count_o (wb_count)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    // memory transfers, logged in their ack cycle
    always @(negedge clk) begin
        if (rst_n && mem_req_o) begin
            req_cycles = req_cycles + 1;
            if (mem_ack_i) begin
                xfer_we_q.push_back(mem_we_o);
                xfer_addr_q.push_back(mem_addr_o);
                if (mem_we_o) begin
                    wb_data_q.push_back(mem_wdata_o);
                end
            end
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic dcache_pkg::line_t ref_line(input dcache_pkg::addr_t addr);
        dcache_pkg::line_t line;
        for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++) begin
            line[w*32 +: 32] = ref_mem[addr[11:4] * 4 + w];
        end
        return line;
    endfunction

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (actual === expected) else begin
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("error at %0t: %s", $time, what);
            stop_run();
        end
    endtask

    // one cpu request, checked against the model, then the model moves on
    task automatic run_access(input dcache_pkg::addr_t addr, input logic we,
                              input dcache_pkg::be_t be, input dcache_pkg::word_t wdata);
        dcache_pkg::addr_t line_addr;
        int                set;
        logic              hit_mru;
        logic              hit_lru;
        logic              exp_wb;
        model_line_t       fill;
        int                wait_cycles;
        int                req_before;
        line_addr  = {addr[31:4], 4'h0};
        set        = addr[7:4];
        hit_mru    = mru[set].valid && mru[set].line == line_addr;
        hit_lru    = lru[set].valid && lru[set].line == line_addr;
        exp_wb     = !hit_mru && !hit_lru && lru[set].valid && lru[set].dirty;
        req_before = req_cycles;
        @(posedge clk);
        cpu_valid_i     <= 1'b1;
        cpu_req_i.addr  <= addr;
        cpu_req_i.we    <= we;
        cpu_req_i.be    <= be;
        cpu_req_i.wdata <= wdata;
        @(negedge clk);
        wait_cycles = 1;
        while (cpu_ack_o !== 1'b1) begin
            @(negedge clk);
            wait_cycles = wait_cycles + 1;
        end
        if (!we) begin
            check_equal("cpu_rdata_o", ref_mem[addr[11:2]], cpu_rdata_o);
        end
        if (hit_mru || hit_lru) begin
            check_equal("cpu_ack_o delay", 2, wait_cycles);   // ack right after acceptance
            check_equal("mem_req_o cycles", req_before, req_cycles);
        end else begin
            check_true(xfer_addr_q.size() == (exp_wb ? 2 : 1),
                       "wrong number of memory transfers on a miss");
            if (exp_wb) begin
                check_equal("mem_we_o", 1, xfer_we_q.pop_front());
                check_equal("mem_addr_o", lru[set].line, xfer_addr_q.pop_front());
                check_equal("mem_wdata_o", ref_line(lru[set].line), wb_data_q.pop_front());
            end
            check_equal("mem_we_o", 0, xfer_we_q.pop_front());
            check_equal("mem_addr_o", line_addr, xfer_addr_q.pop_front());
        end
        for (int b = 0; b < 4; b++) begin
            if (we && be[b]) begin
                ref_mem[addr[11:2]][b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        if (!hit_mru) begin
            fill = lru[set];
            if (!hit_lru) begin
                fill.valid = 1'b1;              // refilled clean
                fill.dirty = 1'b0;
                fill.line  = line_addr;
            end
            lru[set] = mru[set];
            mru[set] = fill;
        end
        mru[set].dirty = mru[set].dirty | we;
        @(posedge clk);
        cpu_valid_i <= 1'b0;
    endtask

    task automatic test_read_miss_hit();
        run_access(32'h0000_0108, 1'b0, 4'h0, '0);     // miss, one line read
        run_access(32'h0000_0104, 1'b0, 4'h0, '0);
        run_access(32'h0000_010C, 1'b0, 4'h0, '0);
    endtask

    task automatic test_write_merge();
        run_access(32'h0000_0108, 1'b1, 4'b0101, 32'hAABB_CCDD);
        run_access(32'h0000_0108, 1'b0, 4'h0, '0);
        run_access(32'h0000_0234, 1'b1, 4'b1100, 32'h1122_3344);   // write miss
        run_access(32'h0000_0234, 1'b0, 4'h0, '0);
    endtask

    // A, B, C all in set 5
    task automatic test_lru_eviction();
        logic [15:0] wb_before;
        run_access(32'h0000_0050, 1'b0, 4'h0, '0);
        run_access(32'h0000_0150, 1'b0, 4'h0, '0);
        run_access(32'h0000_0050, 1'b0, 4'h0, '0);
        wb_before = wb_count;
        run_access(32'h0000_0250, 1'b0, 4'h0, '0);     // clean B goes
        check_equal("wb_count", wb_before, wb_count);
        run_access(32'h0000_0254, 1'b1, 4'hF, 32'hDEAD_BEEF);
        run_access(32'h0000_0050, 1'b0, 4'h0, '0);     // C now least recent
        run_access(32'h0000_0150, 1'b0, 4'h0, '0);     // dirty C written back
        check_equal("wb_count", wb_before + 16'd1, wb_count);
    endtask

    task automatic test_random_traffic();
        dcache_pkg::addr_t addr;
        logic              we;
        dcache_pkg::be_t   be;
        for (int n = 0; n < 200; n++) begin
            rng  = xorshift(rng);
            addr = rng & 32'h0000_033C;               // 4 tags, 4 sets, 4 words
            we   = rng[16];
            be   = rng[23:20];
            rng  = xorshift(rng);
            run_access(addr, we, be, rng);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        cpu_valid_i = 1'b0;
        cpu_req_i   = '0;
        cycle_count = 0;
        req_cycles  = 0;
        rng         = 32'd56;
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = (i * 4) ^ 32'h5A5A_0000;
        end
        for (int s = 0; s < dcache_pkg::SETS; s++) begin
            mru[s] = '0;
            lru[s] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        test_read_miss_hit();
        test_write_merge();
        test_lru_eviction();
        test_random_traffic();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- test/tb_mem_model.sv
// --------------------
// line-wide backing memory for the dcache testbench
// random ack latency of 1 to 8 cycles, counts write-backs
// --------------------

`timescale 1ns/10ps

module tb_mem_model #(
    parameter logic [31:0] SEED = 32'd56
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_i,
    input  logic              we_i,
    input  dcache_pkg::addr_t addr_i,
    input  dcache_pkg::line_t wdata_i,
    output logic              ack_o,
    output dcache_pkg::line_t rdata_o,
    output logic [15:0]       wb_count_o
);

    dcache_pkg::line_t lines [256];    // 4 KB window, line index addr[11:4]
    logic [31:0]       rng;
    logic              busy;
    logic [2:0]        delay;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // each word holds its own byte address xor a fixed mark
    initial begin
        for (int l = 0; l < 256; l++) begin
            for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++) begin
                lines[l][w*32 +: 32] = (l * 16 + w * 4) ^ 32'h5A5A_0000;
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_o      <= 1'b0;
            rdata_o    <= '0;
            busy       <= 1'b0;
            delay      <= 3'd0;
            rng        <= SEED;
            wb_count_o <= 16'd0;
        end else if (ack_o) begin
            ack_o <= 1'b0;                 // transfer done at this edge
            busy  <= 1'b0;
        end else if (busy && delay != 3'd0) begin
            delay <= delay - 3'd1;
        end else if (busy) begin
            ack_o   <= 1'b1;
            rdata_o <= lines[addr_i[11:4]];
            if (we_i) begin
                lines[addr_i[11:4]] <= wdata_i;
                wb_count_o          <= wb_count_o + 16'd1;
            end
        end else if (req_i) begin
            busy  <= 1'b1;
            delay <= rng[2:0];             // latency picked per request
            rng   <= xorshift(rng);
        end
    end

endmodule

//--- hdl/dcache_top.sv
// --------------------
// dcache top level
// two-way write-back data cache between a cpu port
// and a line-wide memory port
// --------------------

`timescale 1ns/10ps

module dcache_top (
    input  logic                 clk,
    input  logic                 rst_n,
    // cpu side
    input  logic                 cpu_valid_i,
    input  dcache_pkg::cpu_req_t cpu_req_i,
    output logic                 cpu_ack_o,
    output dcache_pkg::word_t    cpu_rdata_o,
    // memory side
    output logic                 mem_req_o,
    output logic                 mem_we_o,
    output dcache_pkg::addr_t    mem_addr_o,
    output dcache_pkg::line_t    mem_wdata_o,
    input  logic                 mem_ack_i,
    input  dcache_pkg::line_t    mem_rdata_i
);

    dcache_pkg::cpu_req_t  req;
    dcache_pkg::way_ctrl_t way_ctrl;
    dcache_pkg::way_sel_t  way_we;
    dcache_pkg::way_sel_t  victim;
    dcache_pkg::way_sel_t  hit;
    dcache_pkg::line_t     way_wdata;
    dcache_pkg::line_t     store_line;
    dcache_pkg::tag_t      victim_tag;
    dcache_pkg::line_t     victim_line;
    logic                  victim_dirty;
    dcache_pkg::way_rd_t   way_rd [dcache_pkg::NUM_WAYS];

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .cpu_valid_i    (cpu_valid_i),
        .cpu_req_i      (cpu_req_i),
        .cpu_ack_o      (cpu_ack_o),
        .req_o          (req),
        .way_ctrl_o     (way_ctrl),
        .way_we_o       (way_we),
        .victim_o       (victim),
        .way_wdata_o    (way_wdata),
        .hit_i          (hit),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .victim_line_i  (victim_line),
        .store_line_i   (store_line),
        .mem_req_o      (mem_req_o),
        .mem_we_o       (mem_we_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_ack_i      (mem_ack_i),
        .mem_rdata_i    (mem_rdata_i)
    );

    // --------------------
    // ways
    for (genvar w = 0; w < dcache_pkg::NUM_WAYS; w++) begin : g_way
        dcache_way u_way (
            .clk     (clk),
            .rst_n   (rst_n),
            .ctrl_i  (way_ctrl),
            .we_i    (way_we[w]),
            .wdata_i (way_wdata),
            .rd_o    (way_rd[w])
        );
    end

    dcache_merge u_merge (
        .ways_i         (way_rd),
        .req_i          (req),
        .victim_i       (victim),
        .hit_o          (hit),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag),
        .victim_line_o  (victim_line),
        .rdata_o        (cpu_rdata_o),
        .store_line_o   (store_line)
    );

endmodule

//--- hdl/dcache_ctrl.sv
// --------------------
// dcache controller
// request register, main FSM, per-set LRU bits,
// way write strobes and the memory handshake
// --------------------

`timescale 1ns/10ps

module dcache_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    // cpu side
    input  logic                  cpu_valid_i,
    input  dcache_pkg::cpu_req_t  cpu_req_i,
    output logic                  cpu_ack_o,
    // to ways and merge
    output dcache_pkg::cpu_req_t  req_o,
    output dcache_pkg::way_ctrl_t way_ctrl_o,
    output dcache_pkg::way_sel_t  way_we_o,
    output dcache_pkg::way_sel_t  victim_o,
    output dcache_pkg::line_t     way_wdata_o,
    // from merge
    input  dcache_pkg::way_sel_t  hit_i,
    input  logic                  victim_dirty_i,
    input  dcache_pkg::tag_t      victim_tag_i,
    input  dcache_pkg::line_t     victim_line_i,
    input  dcache_pkg::line_t     store_line_i,
    // memory side
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output dcache_pkg::addr_t     mem_addr_o,
    output dcache_pkg::line_t     mem_wdata_o,
    input  logic                  mem_ack_i,
    input  dcache_pkg::line_t     mem_rdata_i
);

    dcache_pkg::main_state_t state_q;
    dcache_pkg::main_state_t state_d;
    dcache_pkg::cpu_req_t    req_q;
    dcache_pkg::index_t      req_index;
    dcache_pkg::tag_t        req_tag;
    logic [dcache_pkg::SETS-1:0] lru_q;    // 1: way 1 is least recently used
    logic                    any_hit;

    assign req_index = req_q.addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    assign req_tag   = req_q.addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    assign any_hit   = |hit_i;
    assign req_o     = req_q;

    // --------------------
    // main FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::IDLE: begin
                if (cpu_valid_i) begin
                    state_d = dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::LOOKUP: begin
                if (any_hit) begin
                    state_d = dcache_pkg::IDLE;
                end else if (victim_dirty_i) begin
                    state_d = dcache_pkg::WRITEBACK;
                end else begin
                    state_d = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::WRITEBACK: begin
                if (mem_ack_i) begin
                    state_d = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::REFILL: begin
                if (mem_ack_i) begin
                    state_d = dcache_pkg::LOOKUP;    // replay, hits this time
                end
            end
            default: begin
                state_d = dcache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= dcache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request captured on acceptance, held through the miss
    always_ff @(posedge clk) begin
        if (state_q == dcache_pkg::IDLE && cpu_valid_i) begin
            req_q <= cpu_req_i;
        end
    end

    // --------------------
    // LRU
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_q <= '0;
        end else if (state_q == dcache_pkg::LOOKUP && any_hit) begin
            lru_q[req_index] <= hit_i[0];       // point away from the hit way
        end else if (state_q == dcache_pkg::REFILL && mem_ack_i) begin
            lru_q[req_index] <= victim_o[0];    // point away from the refilled way
        end
    end

    assign victim_o = {lru_q[req_index], ~lru_q[req_index]};

    // --------------------
    // way controls
    always_comb begin
        if (state_q == dcache_pkg::IDLE) begin
            way_ctrl_o.index = cpu_req_i.addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
        end else begin
            way_ctrl_o.index = req_index;
        end
        way_ctrl_o.tag       = req_tag;
        way_ctrl_o.wr_line   = (state_q == dcache_pkg::REFILL);
        way_ctrl_o.set_valid = (state_q == dcache_pkg::REFILL);
        way_ctrl_o.dirty_val = (state_q == dcache_pkg::LOOKUP);  // store marks the line dirty
    end

    always_comb begin
        way_we_o = '0;
        if (state_q == dcache_pkg::LOOKUP && req_q.we) begin
            way_we_o = hit_i;
        end else if (state_q == dcache_pkg::REFILL && mem_ack_i) begin
            way_we_o = victim_o;
        end
    end

    assign way_wdata_o = (state_q == dcache_pkg::REFILL) ? mem_rdata_i : store_line_i;

    assign cpu_ack_o = (state_q == dcache_pkg::LOOKUP) && any_hit;

    // --------------------
    // memory port
    assign mem_req_o   = (state_q == dcache_pkg::WRITEBACK) || (state_q == dcache_pkg::REFILL);
    assign mem_we_o    = (state_q == dcache_pkg::WRITEBACK);
    assign mem_wdata_o = victim_line_i;

    always_comb begin
        if (state_q == dcache_pkg::WRITEBACK) begin
            // victim goes back to its own address
            mem_addr_o = {victim_tag_i, req_index, {dcache_pkg::OFFSET_W{1'b0}}};
        end else begin
            mem_addr_o = {req_tag, req_index, {dcache_pkg::OFFSET_W{1'b0}}};
        end
    end

endmodule

//--- hdl/dcache_merge.sv
// --------------------
// dcache way merge
// hit vector, victim fields, read word select
// and byte merge of a store into the hit line
// --------------------

`timescale 1ns/10ps

module dcache_merge (
    input  dcache_pkg::way_rd_t  ways_i [dcache_pkg::NUM_WAYS],
    input  dcache_pkg::cpu_req_t req_i,
    input  dcache_pkg::way_sel_t victim_i,
    output dcache_pkg::way_sel_t hit_o,
    output logic                 victim_dirty_o,
    output dcache_pkg::tag_t     victim_tag_o,
    output dcache_pkg::line_t    victim_line_o,
    output dcache_pkg::word_t    rdata_o,
    output dcache_pkg::line_t    store_line_o
);

    dcache_pkg::line_t hit_line;
    logic [dcache_pkg::OFFSET_W-3:0] word_sel;   // word bits of the offset

    assign word_sel = req_i.addr[dcache_pkg::OFFSET_W-1:2];

    // --------------------
    // way selection
    always_comb begin
        hit_o          = '0;
        hit_line       = '0;
        victim_dirty_o = 1'b0;
        victim_tag_o   = '0;
        victim_line_o  = '0;
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            hit_o[w] = ways_i[w].hit;
            // and-or mux over one-hot selects
            if (ways_i[w].hit) begin
                hit_line = hit_line | ways_i[w].line;
            end
            if (victim_i[w]) begin
                victim_dirty_o = victim_dirty_o | (ways_i[w].valid & ways_i[w].dirty);
                victim_tag_o   = victim_tag_o | ways_i[w].tag;
                victim_line_o  = victim_line_o | ways_i[w].line;
            end
        end
    end

    // read word out of the hit line
    assign rdata_o = hit_line[word_sel*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];

    // --------------------
    // store merge
    always_comb begin
        store_line_o = hit_line;
        for (int i = 0; i < dcache_pkg::WORDS_PER_LINE; i++) begin
            if (word_sel == i) begin
                for (int b = 0; b < dcache_pkg::BE_W; b++) begin
                    if (req_i.be[b]) begin
                        store_line_o[i*dcache_pkg::WORD_W + b*8 +: 8] = req_i.wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- hdl/dcache_way.sv
// --------------------
// dcache way
// tag, line, valid and dirty storage of one way,
// registered index read and hit compare
// --------------------

`timescale 1ns/10ps

module dcache_way (
    input  logic                  clk,
    input  logic                  rst_n,
    input  dcache_pkg::way_ctrl_t ctrl_i,
    input  logic                  we_i,
    input  dcache_pkg::line_t     wdata_i,
    output dcache_pkg::way_rd_t   rd_o
);

    dcache_pkg::tag_t            tag_mem  [dcache_pkg::SETS];
    dcache_pkg::line_t           line_mem [dcache_pkg::SETS];
    logic [dcache_pkg::SETS-1:0] valid_q;
    logic [dcache_pkg::SETS-1:0] dirty_q;
    dcache_pkg::index_t          idx_q;

    // --------------------
    // status bits and read index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            idx_q   <= '0;
        end else begin
            idx_q <= ctrl_i.index;
            if (we_i) begin
                dirty_q[ctrl_i.index] <= ctrl_i.dirty_val;
                if (ctrl_i.set_valid) begin
                    valid_q[ctrl_i.index] <= 1'b1;
                end
            end
        end
    end

    // --------------------
    // arrays
    always_ff @(posedge clk) begin
        if (we_i) begin
            line_mem[ctrl_i.index] <= wdata_i;
            if (ctrl_i.wr_line) begin
                tag_mem[ctrl_i.index] <= ctrl_i.tag;  // new line installed
            end
        end
    end

    // read through the registered index
    always_comb begin
        rd_o.valid = valid_q[idx_q];
        rd_o.dirty = dirty_q[idx_q];
        rd_o.tag   = tag_mem[idx_q];
        rd_o.line  = line_mem[idx_q];
        rd_o.hit   = valid_q[idx_q] && (tag_mem[idx_q] == ctrl_i.tag);
    end

endmodule

//--- hdl/dcache_pkg.sv
// --------------------
// dcache shared definitions
// geometry, field widths, controller states
// and the structs passed between blocks
// --------------------

package dcache_pkg;

    // cache geometry
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
    localparam int OFFSET_W       = 4;   // byte offset in a line
    localparam int INDEX_W        = 4;
    localparam int SETS           = 1 << INDEX_W;
    localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NUM_WAYS       = 2;
    localparam int BE_W           = WORD_W / 8;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [BE_W-1:0]     be_t;
    typedef logic [NUM_WAYS-1:0] way_sel_t;  // one-hot

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL
    } main_state_t;

    // cpu request, held until ack
    typedef struct packed {
        addr_t addr;
        logic  we;
        be_t   be;
        word_t wdata;
    } cpu_req_t;

    // broadcast from the controller to every way
    typedef struct packed {
        index_t index;
        tag_t   tag;
        logic   wr_line;    // install a new line, tag included
        logic   set_valid;
        logic   dirty_val;
    } way_ctrl_t;

    // read result of one way
    typedef struct packed {
        logic  hit;
        logic  valid;
        logic  dirty;
        tag_t  tag;
        line_t line;
    } way_rd_t;

endpackage
